//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps
TOP        := mips_core_tb
FILELIST   := mips_core.f
OBJ_DIR    := obj_dir
PASS_MSG   := All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/decode_stage.sv
`include "mips_config.svh"

module decode_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      hold,
    input  mips_isa_pkg::word_t       f_pc,
    input  mips_isa_pkg::word_t       f_instr,
    input  logic                      redirect,
    input  mips_isa_pkg::word_t       rd1,
    input  mips_isa_pkg::word_t       rd2,
    output mips_isa_pkg::reg_addr_t   ra1,
    output mips_isa_pkg::reg_addr_t   ra2,
    input  mips_isa_pkg::reg_addr_t   e_dest,
    input  logic                      e_reg_we,
    output logic                      stall_d,
    output mips_isa_pkg::word_t       de_pc,
    output mips_pipe_pkg::alu_op_t    de_alu_op,
    output mips_isa_pkg::word_t       de_operand_a,
    output mips_isa_pkg::word_t       de_operand_b,
    output mips_isa_pkg::word_t       de_store_data,
    output mips_pipe_pkg::br_t        de_br,
    output mips_isa_pkg::word_t       de_br_target,
    output mips_isa_pkg::reg_addr_t   de_dest,
    output logic                      de_reg_we,
    output logic                      de_mem_re,
    output logic                      de_mem_we
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    fd_payload_t f_word;
    fd_payload_t d_q;
    fd_payload_t d_bubble;
    opcode_t     opcode;
    funct_t      funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    word_t       imm_sext;
    word_t       imm_zext;
    word_t       pc_plus4;
    logic        dest_rt;
    logic        use_rt;
    logic        reg_we;
    logic        mem_re;
    logic        mem_we;
    br_t         br;

    assign f_word = '{pc: f_pc, instr: f_instr};
    assign d_bubble = '{pc: '0, instr: `MIPS_NOP};

    pipe_reg #(.payload_t(fd_payload_t)) d_reg (
        .clk, .rst,
        .hold(hold | stall_d),
        .flush(redirect),
        .d(f_word), .q(d_q), .bubble(d_bubble)
    );

    assign opcode = opcode_t'(d_q.instr[31:26]);
    assign funct = funct_t'(d_q.instr[5:0]);
    assign rs = d_q.instr[25:21];
    assign rt = d_q.instr[20:16];
    assign imm_sext = {{16{d_q.instr[15]}}, d_q.instr[15:0]};
    assign imm_zext = {16'h0000, d_q.instr[15:0]};
    assign pc_plus4 = d_q.pc + 32'd4;

    always_comb begin
        de_alu_op = ALU_ADD;
        de_operand_a = rd1;
        de_operand_b = rd2;
        dest_rt = 1'b1;
        use_rt = 1'b0;
        reg_we = 1'b1;
        mem_re = 1'b0;
        mem_we = 1'b0;
        br = BR_NONE;
        case (opcode)
            OP_SPECIAL: begin
                dest_rt = 1'b0;
                use_rt = 1'b1;
                case (funct)
                    FN_ADDU: de_alu_op = ALU_ADD;
                    FN_SUBU: de_alu_op = ALU_SUB;
                    FN_AND:  de_alu_op = ALU_AND;
                    FN_OR:   de_alu_op = ALU_OR;
                    FN_XOR:  de_alu_op = ALU_XOR;
                    FN_SLT:  de_alu_op = ALU_SLT;
                    FN_SLL, FN_SRL: begin
                        de_alu_op = (funct == FN_SLL) ? ALU_SLL : ALU_SRL;
                        // shift amount rides in operand a
                        de_operand_a = {27'b0, d_q.instr[10:6]};
                    end
                    default: reg_we = 1'b0;
                endcase
            end
            OP_ADDIU: de_operand_b = imm_sext;
            OP_SLTI: begin
                de_alu_op = ALU_SLT;
                de_operand_b = imm_sext;
            end
            OP_ANDI: begin
                de_alu_op = ALU_AND;
                de_operand_b = imm_zext;
            end
            OP_ORI: begin
                de_alu_op = ALU_OR;
                de_operand_b = imm_zext;
            end
            OP_XORI: begin
                de_alu_op = ALU_XOR;
                de_operand_b = imm_zext;
            end
            OP_LUI: begin
                de_alu_op = ALU_LUI;
                de_operand_b = imm_zext;
            end
            OP_LW: begin
                de_operand_b = imm_sext;
                mem_re = 1'b1;
            end
            OP_SW: begin
                de_operand_b = imm_sext;
                mem_we = 1'b1;
                reg_we = 1'b0;
                use_rt = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                br = (opcode == OP_BEQ) ? BR_EQ : BR_NE;
                reg_we = 1'b0;
                use_rt = 1'b1;
            end
            OP_J: begin
                br = BR_J;
                reg_we = 1'b0;
            end
            default: reg_we = 1'b0;
        endcase
    end

    assign ra1 = rs;
    assign ra2 = rt;

    // RAW against the instruction now in E; R is covered by the regfile bypass
    assign stall_d = e_reg_we && (e_dest == rs || (use_rt && e_dest == rt));

    assign de_pc = d_q.pc;
    assign de_store_data = rd2;
    assign de_dest = dest_rt ? rt : d_q.instr[15:11];
    assign de_br_target = (br == BR_J) ? {pc_plus4[31:28], d_q.instr[25:0], 2'b00}
                                       : pc_plus4 + {imm_sext[29:0], 2'b00};

    // stalled decode issues a bubble
    assign de_reg_we = reg_we && de_dest != '0 && !stall_d;
    assign de_mem_re = mem_re && !stall_d;
    assign de_mem_we = mem_we && !stall_d;
    assign de_br = stall_d ? BR_NONE : br;

    // only branches redirect and they never write a register
    assert property (@(posedge clk) disable iff (rst) !(stall_d && redirect));

endmodule

//--- hdl/execute_stage.sv
module execute_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      hold,
    input  logic                      stall_d,
    input  mips_isa_pkg::word_t       de_pc,
    input  mips_pipe_pkg::alu_op_t    de_alu_op,
    input  mips_isa_pkg::word_t       de_operand_a,
    input  mips_isa_pkg::word_t       de_operand_b,
    input  mips_isa_pkg::word_t       de_store_data,
    input  mips_pipe_pkg::br_t        de_br,
    input  mips_isa_pkg::word_t       de_br_target,
    input  mips_isa_pkg::reg_addr_t   de_dest,
    input  logic                      de_reg_we,
    input  logic                      de_mem_re,
    input  logic                      de_mem_we,
    output logic                      redirect,
    output mips_isa_pkg::word_t       redirect_pc,
    output mips_isa_pkg::reg_addr_t   e_dest,
    output logic                      e_reg_we,
    output mips_isa_pkg::word_t       er_pc,
    output mips_isa_pkg::word_t       er_result,
    output mips_isa_pkg::word_t       er_store_data,
    output mips_isa_pkg::reg_addr_t   er_dest,
    output logic                      er_reg_we,
    output logic                      er_mem_re,
    output logic                      er_mem_we
);
    import mips_pipe_pkg::*;

    de_payload_t e_d;
    de_payload_t e_q;

    assign e_d = '{pc: de_pc, alu_op: de_alu_op, operand_a: de_operand_a,
                   operand_b: de_operand_b, store_data: de_store_data, br: de_br,
                   br_target: de_br_target, dest: de_dest, reg_we: de_reg_we,
                   mem_re: de_mem_re, mem_we: de_mem_we};

    // squashed slot after a taken branch, or the bubble behind a stall
    pipe_reg #(.payload_t(de_payload_t)) e_reg (
        .clk, .rst, .hold,
        .flush(redirect | stall_d),
        .d(e_d), .q(e_q), .bubble('0)
    );

    always_comb begin
        case (e_q.alu_op)
            ALU_ADD: er_result = e_q.operand_a + e_q.operand_b;
            ALU_SUB: er_result = e_q.operand_a - e_q.operand_b;
            ALU_AND: er_result = e_q.operand_a & e_q.operand_b;
            ALU_OR:  er_result = e_q.operand_a | e_q.operand_b;
            ALU_XOR: er_result = e_q.operand_a ^ e_q.operand_b;
            ALU_SLT: er_result = {31'b0, $signed(e_q.operand_a) < $signed(e_q.operand_b)};
            ALU_SLL: er_result = e_q.operand_b << e_q.operand_a[4:0];
            ALU_SRL: er_result = e_q.operand_b >> e_q.operand_a[4:0];
            ALU_LUI: er_result = {e_q.operand_b[15:0], 16'h0000};
            default: er_result = '0;
        endcase
    end

    always_comb begin
        case (e_q.br)
            BR_EQ:   redirect = e_q.operand_a == e_q.operand_b;
            BR_NE:   redirect = e_q.operand_a != e_q.operand_b;
            BR_J:    redirect = 1'b1;
            default: redirect = 1'b0;
        endcase
    end

    assign redirect_pc = e_q.br_target;
    assign e_dest = e_q.dest;
    assign e_reg_we = e_q.reg_we;

    assign er_pc = e_q.pc;
    assign er_store_data = e_q.store_data;
    assign er_dest = e_q.dest;
    assign er_reg_we = e_q.reg_we;
    assign er_mem_re = e_q.mem_re;
    assign er_mem_we = e_q.mem_we;

    // the slot behind a taken branch is a bubble and cannot redirect again
    assert property (@(posedge clk) disable iff (rst) redirect && !hold |=> !redirect);

endmodule

//--- hdl/fetch_stage.sv
`include "mips_config.svh"

module fetch_stage (
    input  logic                clk,
    input  logic                rst,
    output mips_isa_pkg::word_t pc,
    input  mips_isa_pkg::word_t instr,
    input  logic                instr_ok,
    input  logic                stall_d,
    input  logic                hold,
    input  logic                redirect,
    input  mips_isa_pkg::word_t redirect_pc,
    output mips_isa_pkg::word_t f_pc,
    output mips_isa_pkg::word_t f_instr
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `MIPS_RESET_PC;
        end else if (!hold) begin
            if (redirect) begin
                pc <= redirect_pc;
            end else if (!stall_d && instr_ok) begin
                pc <= pc + 32'd4;
            end
        end
    end

    assign f_pc = pc;

    // invalid fetch enters decode as a bubble
    assign f_instr = instr_ok ? instr : `MIPS_NOP;

endmodule

//--- hdl/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// architectural register count
`define MIPS_NREGS 32

// sll r0, r0, 0 doubles as the pipeline bubble
`define MIPS_NOP 32'h0000_0000

`endif

//--- hdl/mips_core.sv
module mips_core (
    input  logic                    clk,
    input  logic                    rst,
    output mips_isa_pkg::word_t     pc,
    input  mips_isa_pkg::word_t     instr,
    input  logic                    instr_ok,
    output mips_isa_pkg::word_t     mem_addr,
    output mips_isa_pkg::word_t     mem_wdata,
    output logic                    mem_re,
    output logic                    mem_we,
    input  mips_isa_pkg::word_t     rd,
    input  logic                    dmem_ok,
    output logic                    rf_we,
    output mips_isa_pkg::reg_addr_t rf_waddr,
    output mips_isa_pkg::word_t     rf_wdata,
    output mips_isa_pkg::word_t     wb_pc
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    // fetch and hazard controls
    word_t     f_pc;
    word_t     f_instr;
    logic      stall_d;
    logic      hold;
    logic      redirect;
    word_t     redirect_pc;
    reg_addr_t e_dest;
    logic      e_reg_we;

    // register file read ports
    reg_addr_t ra1;
    reg_addr_t ra2;
    word_t     rd1;
    word_t     rd2;

    // decode to execute
    word_t     de_pc;
    alu_op_t   de_alu_op;
    word_t     de_operand_a;
    word_t     de_operand_b;
    word_t     de_store_data;
    br_t       de_br;
    word_t     de_br_target;
    reg_addr_t de_dest;
    logic      de_reg_we;
    logic      de_mem_re;
    logic      de_mem_we;

    // execute to result
    word_t     er_pc;
    word_t     er_result;
    word_t     er_store_data;
    reg_addr_t er_dest;
    logic      er_reg_we;
    logic      er_mem_re;
    logic      er_mem_we;

    fetch_stage fetch (
        .clk, .rst, .pc, .instr, .instr_ok, .stall_d, .hold,
        .redirect, .redirect_pc, .f_pc, .f_instr
    );

    decode_stage decode (
        .clk, .rst, .hold, .f_pc, .f_instr, .redirect,
        .rd1, .rd2, .ra1, .ra2, .e_dest, .e_reg_we, .stall_d,
        .de_pc, .de_alu_op, .de_operand_a, .de_operand_b, .de_store_data,
        .de_br, .de_br_target, .de_dest, .de_reg_we, .de_mem_re, .de_mem_we
    );

    execute_stage execute (
        .clk, .rst, .hold, .stall_d,
        .de_pc, .de_alu_op, .de_operand_a, .de_operand_b, .de_store_data,
        .de_br, .de_br_target, .de_dest, .de_reg_we, .de_mem_re, .de_mem_we,
        .redirect, .redirect_pc, .e_dest, .e_reg_we,
        .er_pc, .er_result, .er_store_data, .er_dest,
        .er_reg_we, .er_mem_re, .er_mem_we
    );

    result_stage result (
        .clk, .rst,
        .er_pc, .er_result, .er_store_data, .er_dest,
        .er_reg_we, .er_mem_re, .er_mem_we,
        .mem_addr, .mem_wdata, .mem_re, .mem_we, .rd, .dmem_ok,
        .hold, .rf_we, .rf_waddr, .rf_wdata, .wb_pc
    );

    // written from result, read by decode
    regfile rf (
        .clk, .rst, .ra1, .ra2, .rd1, .rd2,
        .we(rf_we), .wa(rf_waddr), .wd(rf_wdata)
    );

endmodule

//--- hdl/mips_isa_pkg.sv
package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // function field of SPECIAL, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_t;

endpackage

//--- hdl/mips_pipe_pkg.sv
package mips_pipe_pkg;
    import mips_isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_t;

    // control transfer resolved in execute
    typedef enum logic [1:0] {
        BR_NONE, BR_EQ, BR_NE, BR_J
    } br_t;

    // fetch to decode
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fd_payload_t;

    // decode to execute
    typedef struct packed {
        word_t     pc;
        alu_op_t   alu_op;
        word_t     operand_a;
        word_t     operand_b;
        word_t     store_data;
        br_t       br;
        word_t     br_target;
        reg_addr_t dest;
        logic      reg_we;
        logic      mem_re;
        logic      mem_we;
    } de_payload_t;

    // execute to result
    typedef struct packed {
        word_t     pc;
        word_t     result;
        word_t     store_data;
        reg_addr_t dest;
        logic      reg_we;
        logic      mem_re;
        logic      mem_we;
    } er_payload_t;

endpackage

//--- hdl/pipe_reg.sv
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q,
    input  payload_t bubble
);

    // hold wins over flush so a frozen pipeline keeps its contents
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= bubble;
        end else if (!hold) begin
            if (flush) begin
                q <= bubble;
            end else begin
                q <= d;
            end
        end
    end

    // stage comes out of reset empty
    assert property (@(posedge clk) rst |=> q == bubble);

endmodule

//--- hdl/regfile.sv
`include "mips_config.svh"

module regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  mips_isa_pkg::reg_addr_t ra1,
    input  mips_isa_pkg::reg_addr_t ra2,
    output mips_isa_pkg::word_t   rd1,
    output mips_isa_pkg::word_t   rd2,
    input  logic                  we,
    input  mips_isa_pkg::reg_addr_t wa,
    input  mips_isa_pkg::word_t   wd
);
    import mips_isa_pkg::*;

    word_t regs [`MIPS_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

//--- hdl/result_stage.sv
module result_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  mips_isa_pkg::word_t     er_pc,
    input  mips_isa_pkg::word_t     er_result,
    input  mips_isa_pkg::word_t     er_store_data,
    input  mips_isa_pkg::reg_addr_t er_dest,
    input  logic                    er_reg_we,
    input  logic                    er_mem_re,
    input  logic                    er_mem_we,
    output mips_isa_pkg::word_t     mem_addr,
    output mips_isa_pkg::word_t     mem_wdata,
    output logic                    mem_re,
    output logic                    mem_we,
    input  mips_isa_pkg::word_t     rd,
    input  logic                    dmem_ok,
    output logic                    hold,
    output logic                    rf_we,
    output mips_isa_pkg::reg_addr_t rf_waddr,
    output mips_isa_pkg::word_t     rf_wdata,
    output mips_isa_pkg::word_t     wb_pc
);
    import mips_pipe_pkg::*;

    er_payload_t r_d;
    er_payload_t r_q;

    assign r_d = '{pc: er_pc, result: er_result, store_data: er_store_data,
                   dest: er_dest, reg_we: er_reg_we, mem_re: er_mem_re,
                   mem_we: er_mem_we};

    pipe_reg #(.payload_t(er_payload_t)) r_reg (
        .clk, .rst, .hold,
        .flush(1'b0),
        .d(r_d), .q(r_q), .bubble('0)
    );

    // strobes stay up while the whole pipeline waits on dmem_ok
    assign mem_addr = r_q.result;
    assign mem_wdata = r_q.store_data;
    assign mem_re = r_q.mem_re;
    assign mem_we = r_q.mem_we;
    assign hold = (r_q.mem_re | r_q.mem_we) & ~dmem_ok;

    // a load retires only in its dmem_ok cycle
    assign rf_we = r_q.reg_we && r_q.dest != '0 && !(r_q.mem_re && !dmem_ok);
    assign rf_waddr = r_q.dest;
    assign rf_wdata = r_q.mem_re ? rd : r_q.result;
    assign wb_pc = r_q.pc;

    assert property (@(posedge clk) disable iff (rst) !(mem_re && mem_we));

endmodule

//--- mips_core.f
+incdir+hdl
hdl/mips_isa_pkg.sv
hdl/mips_pipe_pkg.sv
hdl/pipe_reg.sv
hdl/regfile.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/mips_core.sv
verification/mips_core_tb.sv

//--- verification/mips_core_tb.sv
`include "mips_config.svh"

module mips_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mips_isa_pkg::*;

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    logic      instr_ok = 1'b1;
    logic      dmem_ok = 1'b1;
    word_t     pc;
    word_t     instr;
    word_t     mem_addr;
    word_t     mem_wdata;
    logic      mem_re;
    logic      mem_we;
    word_t     rd;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;
    word_t     wb_pc;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] load_addr;

    // expected retirement order
    string       exp_name [$];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_waddr [$];
    logic [31:0] exp_wdata [$];

    int   idx;
    int   loads_done;
    int   seed = 32'h9d52_7571;
    logic random_ok = 1'b0;
    int   cycle_count = 0;
    int   cycle_limit = 1000;

    mips_core uut (
        .clk, .rst, .pc, .instr, .instr_ok,
        .mem_addr, .mem_wdata, .mem_re, .mem_we, .rd, .dmem_ok,
        .rf_we, .rf_waddr, .rf_wdata, .wb_pc
    );

    always #20 clk = ~clk;

    // combinational memories
    assign instr = imem[pc[7:2]];
    assign rd = dmem[mem_addr[7:2]];

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= 32'hd0d0_0000 + i;
            end
        end else if (mem_we && dmem_ok) begin
            dmem[mem_addr[7:2]] <= mem_wdata;
        end
    end

    // roughly 70% ready when random mode is on
    always @(posedge clk) begin
        if (random_ok) begin
            instr_ok <= ($unsigned($random(seed)) % 32'd10) < 32'd7;
            dmem_ok <= ($unsigned($random(seed)) % 32'd10) < 32'd7;
        end else begin
            instr_ok <= 1'b1;
            dmem_ok <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Some tests failed");
            $fatal(1, "Timeout: the program did not finish within %0d cycles", cycle_limit);
        end
    end

    function automatic logic [31:0] rtype_word(input logic [5:0] fn, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] rdst,
                                               input logic [4:0] sa);
        return {OP_SPECIAL, rs, rt, rdst, sa, fn};
    endfunction

    function automatic logic [31:0] imm_word(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jump_word(input logic [31:0] target);
        return {OP_J, target[27:2]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Some tests failed");
            $fatal(1, "Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // slot whose instruction retires a register write
    task automatic load_retiring(input string name, input logic [31:0] word,
                                 input logic [4:0] waddr, input logic [31:0] wdata);
        imem[load_addr[7:2]] = word;
        exp_name.push_back(name);
        exp_pc.push_back(load_addr);
        exp_waddr.push_back(waddr);
        exp_wdata.push_back(wdata);
        load_addr = load_addr + 32'd4;
    endtask

    task automatic load_silent(input logic [31:0] word);
        imem[load_addr[7:2]] = word;
        load_addr = load_addr + 32'd4;
    endtask

    task automatic build_program;
        // unused slots jump to themselves
        for (int i = 0; i < 64; i++) begin
            imem[i] = jump_word(32'(i) << 2);
        end
        load_addr = `MIPS_RESET_PC;
        load_retiring("addiu r1", imm_word(OP_ADDIU, 5'd0, 5'd1, 16'h0005), 5'd1, 32'h5);
        load_retiring("addiu r2", imm_word(OP_ADDIU, 5'd0, 5'd2, 16'hfffd), 5'd2, 32'hfffffffd);
        load_retiring("addu r3", rtype_word(FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0), 5'd3, 32'h2);
        load_retiring("subu r4", rtype_word(FN_SUBU, 5'd1, 5'd2, 5'd4, 5'd0), 5'd4, 32'h8);
        load_retiring("slt r5", rtype_word(FN_SLT, 5'd2, 5'd1, 5'd5, 5'd0), 5'd5, 32'h1);
        load_retiring("slt r6", rtype_word(FN_SLT, 5'd1, 5'd2, 5'd6, 5'd0), 5'd6, 32'h0);
        load_retiring("and r7", rtype_word(FN_AND, 5'd1, 5'd2, 5'd7, 5'd0), 5'd7, 32'h5);
        load_retiring("or r8", rtype_word(FN_OR, 5'd1, 5'd2, 5'd8, 5'd0), 5'd8, 32'hfffffffd);
        load_retiring("xor r9", rtype_word(FN_XOR, 5'd1, 5'd2, 5'd9, 5'd0), 5'd9, 32'hfffffff8);
        load_retiring("sll r10", rtype_word(FN_SLL, 5'd0, 5'd1, 5'd10, 5'd4), 5'd10, 32'h50);
        load_retiring("srl r11", rtype_word(FN_SRL, 5'd0, 5'd2, 5'd11, 5'd28), 5'd11, 32'hf);
        load_retiring("lui r12", imm_word(OP_LUI, 5'd0, 5'd12, 16'h1234), 5'd12, 32'h12340000);
        load_retiring("ori r12", imm_word(OP_ORI, 5'd12, 5'd12, 16'h5678), 5'd12, 32'h12345678);
        load_retiring("andi r13", imm_word(OP_ANDI, 5'd12, 5'd13, 16'hff0f), 5'd13, 32'h5608);
        load_retiring("xori r14", imm_word(OP_XORI, 5'd12, 5'd14, 16'hffff), 5'd14, 32'h1234a987);
        load_retiring("slti r15", imm_word(OP_SLTI, 5'd2, 5'd15, 16'hfffe), 5'd15, 32'h1);
        load_retiring("addiu r16", imm_word(OP_ADDIU, 5'd0, 5'd16, 16'h0040), 5'd16, 32'h40);
        load_silent(imm_word(OP_SW, 5'd16, 5'd12, 16'h0008));
        load_retiring("lw r17", imm_word(OP_LW, 5'd16, 5'd17, 16'h0008), 5'd17, 32'h12345678);
        load_retiring("addu r18", rtype_word(FN_ADDU, 5'd17, 5'd1, 5'd18, 5'd0), 5'd18, 32'h1234567d);
        // taken beq to 0x5c skips two slots
        load_silent(imm_word(OP_BEQ, 5'd1, 5'd1, 16'h0002));
        load_silent(imm_word(OP_ADDIU, 5'd0, 5'd19, 16'h0099));
        load_silent(imm_word(OP_ADDIU, 5'd0, 5'd19, 16'h0098));
        load_silent(imm_word(OP_BNE, 5'd1, 5'd1, 16'h0001));
        load_retiring("addiu r20", imm_word(OP_ADDIU, 5'd0, 5'd20, 16'h0014), 5'd20, 32'h14);
        load_silent(jump_word(32'h70));
        load_silent(imm_word(OP_ADDIU, 5'd0, 5'd21, 16'h0077));
        load_silent(imm_word(OP_ADDIU, 5'd0, 5'd21, 16'h0076));
        load_retiring("addiu r22", imm_word(OP_ADDIU, 5'd20, 5'd22, 16'h0001), 5'd22, 32'h15);
        load_silent(jump_word(32'h74));
    endtask

    // outputs stay quiet on every reset edge
    task automatic apply_reset;
        @(posedge clk);
        rst <= 1'b1;
        repeat (15) begin
            @(posedge clk);
            @(negedge clk);
            check_value("reset rf_we", 32'h0, {31'b0, rf_we});
            check_value("reset mem_re", 32'h0, {31'b0, mem_re});
            check_value("reset mem_we", 32'h0, {31'b0, mem_we});
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset pc", `MIPS_RESET_PC, pc);
    endtask

    initial begin
        build_program();
        cycle_limit = 2 * (8 * exp_pc.size() + 200);
        // second pass runs with random ready levels
        for (int pass = 0; pass < 2; pass++) begin
            apply_reset();
            random_ok <= (pass == 1);
            idx = 0;
            loads_done = 0;
            while (idx < exp_pc.size()) begin
                @(negedge clk);
                if (mem_we) begin
                    check_value("sw mem_addr", 32'h48, mem_addr);
                    check_value("sw mem_wdata", 32'h12345678, mem_wdata);
                end
                if (mem_re) begin
                    check_value("lw mem_addr", 32'h48, mem_addr);
                    if (dmem_ok) begin
                        loads_done++;
                    end
                end
                if (rf_we) begin
                    check_value({exp_name[idx], " wb_pc"}, exp_pc[idx], wb_pc);
                    check_value({exp_name[idx], " rf_waddr"}, {27'b0, exp_waddr[idx]},
                                {27'b0, rf_waddr});
                    check_value({exp_name[idx], " rf_wdata"}, exp_wdata[idx], rf_wdata);
                    idx++;
                end
            end
            // the single lw completes exactly once
            check_value("lw mem_re count", 32'd1, 32'(loads_done));
            // self loop at the end must stay silent
            repeat (20) begin
                @(negedge clk);
                if (rf_we) begin
                    $display("Some tests failed");
                    $fatal(1, "Unexpected register write from pc %h after the program ended",
                           wb_pc);
                end
            end
        end
        $display("All tests passed");
        $finish;
    end

endmodule
